/* hdl/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int OPC_W  = 7;

  typedef logic [XLEN-1:0]   word_t;      // data word, instruction or address
  typedef logic [REG_AW-1:0] reg_addr_t;  // register index
  typedef logic [3:0]        alu_fn_t;

  // alu function codes
  localparam alu_fn_t ALU_ADD  = 4'd0;
  localparam alu_fn_t ALU_SUB  = 4'd1;
  localparam alu_fn_t ALU_AND  = 4'd2;
  localparam alu_fn_t ALU_OR   = 4'd3;
  localparam alu_fn_t ALU_XOR  = 4'd4;
  localparam alu_fn_t ALU_SLT  = 4'd5;
  localparam alu_fn_t ALU_SLTU = 4'd6;
  localparam alu_fn_t ALU_SLL  = 4'd7;
  localparam alu_fn_t ALU_SRL  = 4'd8;
  localparam alu_fn_t ALU_SRA  = 4'd9;

  // major opcodes of the supported subset
  localparam logic [OPC_W-1:0] OP_REG   = 7'b0110011;
  localparam logic [OPC_W-1:0] OP_IMM   = 7'b0010011;
  localparam logic [OPC_W-1:0] OP_LOAD  = 7'b0000011;
  localparam logic [OPC_W-1:0] OP_STORE = 7'b0100011;

  // funct3 values shared by register and immediate arithmetic
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra, split by bit 30
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // register fields inside the instruction word
  localparam int RD_LSB  = 7;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;

  localparam reg_addr_t REG_X0   = 5'd0;
  localparam word_t     NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    alu_fn_t   alu_fn;
    logic      use_imm;    // operand two from imm instead of rs2
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
  } id_ex_t;

  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs2;        // kept for load-store forwarding in mem
    word_t     store_data;
    word_t     alu_result;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } wb_t;

endpackage

/* hdl/fetch_stage.sv */
module fetch_stage (
  input  logic           CLK,
  input  logic           reset,
  input  logic           stall,
  input  rv_pkg::word_t  inst,
  output rv_pkg::word_t  pc,
  output rv_pkg::if_id_t if_id
);
  import rv_pkg::*;

  word_t pc_next;

  assign pc_next = pc + 32'd4;

  // pc register, frozen while decode waits on a load
  always_ff @(posedge CLK)
  begin
    if (reset)
      pc <= '0;
    else if (!stall)
      pc <= pc_next;
  end

  // IF/ID register
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      if_id.pc   <= '0;
      if_id.inst <= NOP_INST;  // decodes as a bubble
    end
    else if (!stall)
    begin
      if_id.pc   <= pc;
      if_id.inst <= inst;      // imem answers in the same cycle
    end
  end

  // no branches, so every fetch address stays on a word boundary
  a_pc_aligned: assert property (@(posedge CLK) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

/* hdl/decode_stage.sv */
module decode_stage (
  input  logic              CLK,
  input  logic              reset,
  input  rv_pkg::if_id_t    if_id,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::wb_t       wb,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output logic              stall,
  output rv_pkg::id_ex_t    id_ex
);
  import rv_pkg::*;

  logic [OPC_W-1:0] opcode;
  logic [2:0]       funct3;
  logic             alt;      // inst[30], selects sub / sra
  reg_addr_t        rd_addr;
  word_t            imm_i;
  word_t            imm_s;
  alu_fn_t          alu_fn;
  logic             use_imm;
  logic             mem_read;
  logic             mem_write;
  logic             reg_write;
  logic             is_store;
  word_t            rs1_fwd;
  word_t            rs2_fwd;
  id_ex_t           id_ex_d;

  // same funct3 table for register and immediate forms
  function automatic alu_fn_t alu_decode(logic [2:0] f3, logic alt_bit, logic is_reg);
    alu_fn_t fn;
    case (f3)
      F3_ADD:  fn = (is_reg && alt_bit) ? ALU_SUB : ALU_ADD;  // no subi
      F3_SLL:  fn = ALU_SLL;
      F3_SLT:  fn = ALU_SLT;
      F3_SLTU: fn = ALU_SLTU;
      F3_XOR:  fn = ALU_XOR;
      F3_SR:   fn = alt_bit ? ALU_SRA : ALU_SRL;
      F3_OR:   fn = ALU_OR;
      default: fn = ALU_AND;
    endcase
    return fn;
  endfunction

  assign opcode   = if_id.inst[OPC_W-1:0];
  assign funct3   = if_id.inst[14:12];
  assign alt      = if_id.inst[30];
  assign rd_addr  = if_id.inst[RD_LSB +: REG_AW];
  assign rs1_addr = if_id.inst[RS1_LSB +: REG_AW];
  assign rs2_addr = if_id.inst[RS2_LSB +: REG_AW];
  assign is_store = (opcode == OP_STORE);

  assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
  assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};

  always_comb
  begin
    alu_fn    = ALU_ADD;   // loads and stores add base and offset
    use_imm   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    case (opcode)
      OP_REG:
      begin
        alu_fn    = alu_decode(funct3, alt, 1'b1);
        reg_write = 1'b1;
      end
      OP_IMM:
      begin
        alu_fn    = alu_decode(funct3, alt, 1'b0);
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LOAD:
      begin
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      OP_STORE:
      begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
      end
      default: ;           // unsupported opcode becomes a bubble
    endcase
    if (rd_addr == REG_X0)
      reg_write = 1'b0;    // x0 is never written
  end

  // load in EX whose result is needed here; a store only needs rs1 early
  assign stall = id_ex.mem_read &&
                 ((id_ex.rd == rs1_addr) || ((id_ex.rd == rs2_addr) && !is_store));

  // rf write of this cycle lands after the read, take it directly
  assign rs1_fwd = (wb.we && wb.addr == rs1_addr) ? wb.data : rs1_data;
  assign rs2_fwd = (wb.we && wb.addr == rs2_addr) ? wb.data : rs2_data;

  always_comb
  begin
    id_ex_d.rd        = rd_addr;
    id_ex_d.rs1       = rs1_addr;
    id_ex_d.rs2       = rs2_addr;
    id_ex_d.rs1_data  = rs1_fwd;
    id_ex_d.rs2_data  = rs2_fwd;
    id_ex_d.imm       = is_store ? imm_s : imm_i;
    id_ex_d.alu_fn    = alu_fn;
    id_ex_d.use_imm   = use_imm;
    id_ex_d.mem_read  = mem_read  && !stall;
    id_ex_d.mem_write = mem_write && !stall;
    id_ex_d.reg_write = reg_write && !stall;
  end

  // ID/EX register
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      id_ex.mem_read  <= 1'b0;
      id_ex.mem_write <= 1'b0;
      id_ex.reg_write <= 1'b0;
    end
    else
      id_ex <= id_ex_d;
  end

  a_bubble_inert: assert property (@(posedge CLK) disable iff (reset)
    stall |=> !id_ex.mem_write && !id_ex.reg_write);

endmodule

/* hdl/execute_stage.sv */
module execute_stage (
  input  logic            CLK,
  input  logic            reset,
  input  rv_pkg::id_ex_t  id_ex,
  input  rv_pkg::wb_t     wb,
  output rv_pkg::ex_mem_t ex_mem
);
  import rv_pkg::*;

  word_t   rs1_fwd;
  word_t   rs2_fwd;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_out;
  logic    lt_signed;
  logic    lt_unsigned;
  ex_mem_t ex_mem_d;

  // newest producer first; a load in EX/MEM has no data yet
  function automatic word_t fwd(reg_addr_t src, word_t reg_data);
    word_t val;
    if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == src)
      val = ex_mem.alu_result;
    else if (wb.we && wb.addr == src)
      val = wb.data;
    else
      val = reg_data;
    return val;
  endfunction

  always_comb
  begin
    rs1_fwd = fwd(id_ex.rs1, id_ex.rs1_data);
    rs2_fwd = fwd(id_ex.rs2, id_ex.rs2_data);
  end

  assign op_a = rs1_fwd;
  assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb
  begin
    case (id_ex.alu_fn)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_AND:  alu_out = op_a & op_b;
      ALU_OR:   alu_out = op_a | op_b;
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_SLL:  alu_out = op_a << op_b[4:0];     // shamt from low five bits
      ALU_SRL:  alu_out = op_a >> op_b[4:0];
      ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      default:  alu_out = '0;
    endcase
  end

  always_comb
  begin
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.rs2        = id_ex.rs2;
    ex_mem_d.store_data = rs2_fwd;               // forwarded value, not the stale rf read
    ex_mem_d.alu_result = alu_out;               // address for loads and stores
    ex_mem_d.mem_read   = id_ex.mem_read;
    ex_mem_d.mem_write  = id_ex.mem_write;
    ex_mem_d.reg_write  = id_ex.reg_write;
  end

  // EX/MEM register
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.reg_write <= 1'b0;
    end
    else
      ex_mem <= ex_mem_d;
  end

endmodule

/* hdl/mem_wb_stage.sv */
module mem_wb_stage (
  input  logic            CLK,
  input  logic            reset,
  input  rv_pkg::ex_mem_t ex_mem,
  input  rv_pkg::word_t   mem_rdata,
  output logic            mem_csn,
  output logic            mem_wen,
  output rv_pkg::word_t   mem_addr,
  output rv_pkg::word_t   mem_wdata,
  output rv_pkg::wb_t     wb
);
  import rv_pkg::*;

  logic      mem_wb_we;
  logic      mem_wb_load;   // write back the load data, not the alu result
  reg_addr_t mem_wb_rd;
  word_t     mem_wb_alu;
  word_t     mem_wb_rdata;
  logic      store_fwd;

  // data memory, active low strobes
  assign mem_csn  = !(ex_mem.mem_read || ex_mem.mem_write);
  assign mem_wen  = !ex_mem.mem_write;
  assign mem_addr = ex_mem.alu_result;

  // load directly followed by a store of the loaded register
  assign store_fwd = ex_mem.mem_write && wb.we && (wb.addr == ex_mem.rs2);
  assign mem_wdata = store_fwd ? wb.data : ex_mem.store_data;

  // MEM/WB register
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      mem_wb_we   <= 1'b0;
      mem_wb_load <= 1'b0;
    end
    else
    begin
      mem_wb_we   <= ex_mem.reg_write;
      mem_wb_load <= ex_mem.mem_read;
    end
    mem_wb_rd    <= ex_mem.rd;
    mem_wb_alu   <= ex_mem.alu_result;
    mem_wb_rdata <= mem_rdata;
  end

  always_comb
  begin
    wb.we   = mem_wb_we;
    wb.addr = mem_wb_rd;
    wb.data = mem_wb_load ? mem_wb_rdata : mem_wb_alu;
  end

  // decode drops reg_write for rd x0, nothing downstream may revive it
  a_no_x0_write: assert property (@(posedge CLK) disable iff (reset)
    wb.we |-> wb.addr != REG_X0);

endmodule

/* hdl/riscv_core.sv */
module riscv_core (
  input  logic              CLK,
  input  logic              reset,
  // instruction memory
  output rv_pkg::word_t     I_MEM_ADDR,
  input  rv_pkg::word_t     I_MEM_DI,
  output logic              I_MEM_CSN,
  // data memory
  output logic              D_MEM_CSN,
  output logic              D_MEM_WEN,
  output rv_pkg::word_t     D_MEM_ADDR,
  output rv_pkg::word_t     D_MEM_DOUT,
  input  rv_pkg::word_t     D_MEM_DI,
  // register file
  output rv_pkg::reg_addr_t RF_RA1,
  output rv_pkg::reg_addr_t RF_RA2,
  input  rv_pkg::word_t     RF_RD1,
  input  rv_pkg::word_t     RF_RD2,
  output logic              RF_WE,
  output rv_pkg::reg_addr_t RF_WA,
  output rv_pkg::word_t     RF_WD
);
  import rv_pkg::*;

  logic    stall;
  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;

  assign I_MEM_CSN = 1'b0;   // fetch every cycle

  fetch_stage u_fetch (
    .CLK   (CLK),
    .reset (reset),
    .stall (stall),
    .inst  (I_MEM_DI),
    .pc    (I_MEM_ADDR),
    .if_id (if_id)
  );

  decode_stage u_decode (
    .CLK      (CLK),
    .reset    (reset),
    .if_id    (if_id),
    .rs1_data (RF_RD1),
    .rs2_data (RF_RD2),
    .wb       (wb),
    .rs1_addr (RF_RA1),
    .rs2_addr (RF_RA2),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .CLK    (CLK),
    .reset  (reset),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .CLK       (CLK),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_rdata (D_MEM_DI),
    .mem_csn   (D_MEM_CSN),
    .mem_wen   (D_MEM_WEN),
    .mem_addr  (D_MEM_ADDR),
    .mem_wdata (D_MEM_DOUT),
    .wb        (wb)
  );

  // rf write port, written on the next rising edge
  assign RF_WE = wb.we;
  assign RF_WA = wb.addr;
  assign RF_WD = wb.data;

endmodule

/* verif/tb_core.sv */
module tb_core;
  import rv_pkg::*;

  localparam int PERIOD     = 100;
  localparam int N_TESTS    = 5;
  localparam int PROG_TOTAL = 41;  // 19 + 7 + 5 + 6 + 4 instructions

  logic CLK;
  logic reset;
  word_t i_mem_addr, i_mem_di, d_mem_addr, d_mem_dout, d_mem_di;
  word_t rf_rd1, rf_rd2, rf_wd;
  logic i_mem_csn, d_mem_csn, d_mem_wen, rf_we;
  reg_addr_t rf_ra1, rf_ra2, rf_wa;

  word_t imem [0:63];
  word_t dmem [0:63];
  word_t rf   [0:31];
  word_t mreg [0:31];  // register state in program order
  word_t mmem [0:63];

  int n_inst;
  int stalls;
  int last_load_rd;
  reg_addr_t q_wa [$];
  word_t     q_wd [$];
  int        q_wc [$];
  logic      q_mw [$];
  word_t     q_ma [$];
  word_t     q_md [$];
  int        q_mc [$];
  logic [31:0] lfsr_state = 32'd84909;

  riscv_core DUT (
    .CLK(CLK), .reset(reset),
    .I_MEM_ADDR(i_mem_addr), .I_MEM_DI(i_mem_di), .I_MEM_CSN(i_mem_csn),
    .D_MEM_CSN(d_mem_csn), .D_MEM_WEN(d_mem_wen), .D_MEM_ADDR(d_mem_addr),
    .D_MEM_DOUT(d_mem_dout), .D_MEM_DI(d_mem_di),
    .RF_RA1(rf_ra1), .RF_RA2(rf_ra2), .RF_RD1(rf_rd1), .RF_RD2(rf_rd2),
    .RF_WE(rf_we), .RF_WA(rf_wa), .RF_WD(rf_wd)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(PERIOD/2) CLK = ~CLK;
  end

  // memories and register file answer combinationally
  assign i_mem_di = imem[i_mem_addr[7:2]];
  assign d_mem_di = dmem[d_mem_addr[7:2]];
  assign rf_rd1   = rf[rf_ra1];
  assign rf_rd2   = rf[rf_ra2];

  always @(posedge CLK)
  begin
    if (rf_we)
      rf[rf_wa] <= rf_wd;
    if (!d_mem_csn && !d_mem_wen)
      dmem[d_mem_addr[7:2]] <= d_mem_dout;
  end

  initial
  begin
    #((PROG_TOTAL + 20 * N_TESTS) * PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $fatal(1);
  end

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_run("value mismatch");
    end
  endtask

  task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_run("register index mismatch");
    end
  endtask

  // taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // RV32I arithmetic as the ISA defines it
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, logic is_reg, word_t a, word_t b);
    word_t r;
    case (f3)
      3'd0: r = (is_reg && alt) ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, $signed(a) < $signed(b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic clear_prog();
    n_inst = 0;
    stalls = 0;
    last_load_rd = -1;
    q_wa.delete();
    q_wd.delete();
    q_wc.delete();
    q_mw.delete();
    q_ma.delete();
    q_md.delete();
    q_mc.delete();
    for (int i = 0; i < 64; i++)
    begin
      imem[i] = NOP_INST;
      dmem[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};  // differs at every address
      mmem[i] = dmem[i];
    end
    rf[0] = '0;
    for (int r = 1; r < 32; r++)
      rf[r] = lfsr_bits(32);
    mreg = rf;
  endtask

  task automatic set_reg(reg_addr_t r, word_t v);
    rf[r] = v;
    mreg[r] = v;
  endtask

  // places one instruction and counts the load-use bubble it will see
  task automatic add_inst(word_t inst, int rs1, int rs2, logic needs_rs2);
    if (last_load_rd > 0 && (last_load_rd == rs1 || (needs_rs2 && last_load_rd == rs2)))
      stalls++;
    imem[n_inst] = inst;
    n_inst++;
    last_load_rd = -1;
  endtask

  task automatic expect_wr(reg_addr_t rd, word_t val);
    if (rd != 0)
    begin
      mreg[rd] = val;
      q_wa.push_back(rd);
      q_wd.push_back(val);
      q_wc.push_back(n_inst - 1 + 4 + stalls);
    end
  endtask

  task automatic expect_mem(logic wr, word_t addr, word_t data);
    q_mw.push_back(wr);
    q_ma.push_back(addr);
    q_md.push_back(data);
    q_mc.push_back(n_inst - 1 + 3 + stalls);
  endtask

  task automatic op_rr(logic [2:0] f3, logic alt, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    word_t val;
    val = alu_ref(f3, alt, 1'b1, mreg[rs1], mreg[rs2]);
    add_inst({1'b0, alt, 5'd0, rs2, rs1, f3, rd, OP_REG}, rs1, rs2, 1'b1);
    expect_wr(rd, val);
  endtask

  task automatic op_ri(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    word_t val;
    val = alu_ref(f3, imm[10], 1'b0, mreg[rs1], sext12(imm));
    add_inst({imm, rs1, f3, rd, OP_IMM}, rs1, 0, 1'b0);
    expect_wr(rd, val);
  endtask

  task automatic op_lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    word_t a;
    a = mreg[rs1] + sext12(imm);
    add_inst({imm, rs1, 3'b010, rd, OP_LOAD}, rs1, 0, 1'b0);
    expect_mem(1'b0, a, '0);
    expect_wr(rd, mmem[a[7:2]]);
    last_load_rd = rd;
  endtask

  task automatic op_sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
    word_t a;
    a = mreg[rs1] + sext12(imm);
    add_inst({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}, rs1, rs2, 1'b0);
    expect_mem(1'b1, a, mreg[rs2]);
    mmem[a[7:2]] = mreg[rs2];
  endtask

  task automatic run_prog();
    @(posedge CLK);
    #10 reset = 1'b1;
    repeat (10)
    begin
      @(posedge CLK);
      #10;
      check_word("RF_WE", word_t'(rf_we), 32'd0);
      check_word("D_MEM_CSN", word_t'(d_mem_csn), 32'd1);
    end
    reset = 1'b0;
    for (int cyc = 0; cyc < n_inst + stalls + 6; cyc++)
    begin
      @(negedge CLK);
      check_word("I_MEM_CSN", word_t'(i_mem_csn), 32'd0);
      if (stalls == 0)
        check_word("I_MEM_ADDR", i_mem_addr, word_t'(cyc * 4));
      if (rf_we)
      begin
        if (q_wa.size() == 0)
          stop_run("register file written with no write expected");
        check_reg("RF_WA", rf_wa, q_wa[0]);
        check_word("RF_WD", rf_wd, q_wd[0]);
        if (q_wc[0] != cyc)
          stop_run("register write came in the wrong cycle");
        void'(q_wa.pop_front());
        void'(q_wd.pop_front());
        void'(q_wc.pop_front());
      end
      if (!d_mem_csn)
      begin
        if (q_ma.size() == 0)
          stop_run("data memory accessed with no access expected");
        check_word("D_MEM_ADDR", d_mem_addr, q_ma[0]);
        check_word("D_MEM_WEN", word_t'(d_mem_wen), word_t'(!q_mw[0]));
        if (q_mw[0])
          check_word("D_MEM_DOUT", d_mem_dout, q_md[0]);
        if (q_mc[0] != cyc)
          stop_run("data memory access came in the wrong cycle");
        void'(q_mw.pop_front());
        void'(q_ma.pop_front());
        void'(q_md.pop_front());
        void'(q_mc.pop_front());
      end
    end
    if (q_wa.size() != 0)
      stop_run("an expected register write never happened");
    if (q_ma.size() != 0)
      stop_run("an expected data memory access never happened");
  endtask

  task automatic test_alu();
    logic [2:0] r_f3 [0:9];
    logic       r_alt [0:9];
    logic [2:0] i_f3 [0:8];
    logic [11:0] imm;
    logic [4:0]  shamt;
    r_f3  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    r_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    i_f3  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    clear_prog();
    for (int i = 0; i < 10; i++)
      op_rr(r_f3[i], r_alt[i], reg_addr_t'(10 + i),
            reg_addr_t'(1 + i % 2), reg_addr_t'(3 + i % 2));
    for (int i = 0; i < 9; i++)
    begin
      if (i < 6)
        imm = lfsr_bits(12);
      else
      begin
        shamt = lfsr_bits(5);
        imm   = {1'b0, i == 8, 5'd0, shamt};  // bit 10 picks srai
      end
      op_ri(i_f3[i], reg_addr_t'(20 + i), reg_addr_t'(1 + i % 4), imm);
    end
    run_prog();
  endtask

  task automatic test_chains();
    clear_prog();
    op_ri(3'd0, 5, 1, lfsr_bits(12));
    op_rr(3'd0, 1'b0, 6, 5, 2);    // distance 1
    op_rr(3'd0, 1'b1, 7, 5, 3);    // distance 2
    op_rr(3'd6, 1'b0, 8, 5, 6);    // distance 3 and 2
    op_rr(3'd7, 1'b0, 9, 8, 7);
    op_rr(3'd2, 1'b0, 10, 9, 1);
    op_rr(3'd5, 1'b1, 11, 8, 10);
    run_prog();
  endtask

  task automatic test_store();
    clear_prog();
    op_ri(3'd0, 5, 0, 12'd64);
    op_sw(1, 5, 12'd8);
    op_lw(6, 5, 12'd8);
    op_sw(2, 5, 12'hffc);
    op_lw(7, 5, 12'hffc);
    run_prog();
  endtask

  task automatic test_load_use();
    clear_prog();
    set_reg(1, 32'd32);
    op_lw(5, 1, 12'd0);
    op_rr(3'd0, 1'b0, 6, 5, 2);    // one bubble
    op_lw(7, 1, 12'd4);
    op_sw(7, 1, 12'd16);           // store data from the load in MEM/WB
    op_lw(8, 1, 12'd16);
    op_rr(3'd0, 1'b0, 9, 8, 8);
    run_prog();
  endtask

  task automatic test_unsupported();
    clear_prog();
    op_ri(3'd0, 5, 1, lfsr_bits(12));
    add_inst(32'h1234_52b7, 0, 0, 1'b0);  // lui x5
    add_inst(32'h0020_8463, 0, 0, 1'b0);  // beq
    op_rr(3'd0, 1'b0, 6, 5, 2);
    run_prog();
  endtask

  initial
  begin
    reset = 1'b1;
    test_alu();
    test_chains();
    test_store();
    test_load_use();
    test_unsupported();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* sources.f */
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/riscv_core.sv
verif/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_core -o sim_core
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_core 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
echo "pass message not found"
exit 1
